// ==== include/csr_params.svh ====
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// data path and pc width, rv32 only
`define CSR_XLEN 32

// clock cycles per mtime tick
`define CSR_RTC_DIV 4

// value returned by mhartid
`define CSR_HART_ID 0

`endif

// ==== verilog/csr_pkg.sv ====
package csr_pkg;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_mode_t;

  // funct3 of the zicsr instructions
  typedef enum logic [2:0] {
    CSRRW  = 3'b001,
    CSRRS  = 3'b010,
    CSRRC  = 3'b011,
    CSRRWI = 3'b101,
    CSRRSI = 3'b110,
    CSRRCI = 3'b111
  } csr_op_t;

  localparam logic [11:0] CSR_MSTATUS  = 12'h300;
  localparam logic [11:0] CSR_MISA     = 12'h301;
  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MSTATUSH = 12'h310;
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;
  localparam logic [11:0] CSR_MHARTID  = 12'hf14;

  localparam logic [11:0] CSR_STVEC    = 12'h105;
  localparam logic [11:0] CSR_SEPC     = 12'h141;
  localparam logic [11:0] CSR_SCAUSE   = 12'h142;

  localparam logic [11:0] CSR_CYCLE    = 12'hc00;
  localparam logic [11:0] CSR_TIME     = 12'hc01;
  localparam logic [11:0] CSR_INSTRET  = 12'hc02;
  localparam logic [11:0] CSR_CYCLEH   = 12'hc80;
  localparam logic [11:0] CSR_TIMEH    = 12'hc81;
  localparam logic [11:0] CSR_INSTRETH = 12'hc82;

  // mstatus field positions
  localparam int MSTATUS_SIE  = 1;
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_SPIE = 5;
  localparam int MSTATUS_MPIE = 7;
  localparam int MSTATUS_SPP  = 8;
  localparam int MSTATUS_MPP  = 11; // two bits, 12:11
  localparam int MSTATUS_SUM  = 18;

  localparam logic [31:0] TRAP_BREAKPOINT = 32'd3;
  localparam logic [31:0] TRAP_ECALL_U    = 32'd8; // + mode gives ecall from s/m

  localparam logic [4:0] OPCODE_SYSTEM = 5'h1c;

endpackage

// ==== verilog/csr_sys_if.sv ====
`timescale 1ns/1ns

`include "csr_params.svh"

// decoded SYSTEM instruction, valid only while i_req is high
interface csr_sys_if;
  logic                  csr_valid;
  csr_pkg::csr_op_t      op;
  logic [11:0]           addr;
  logic                  trap;
  logic [`CSR_XLEN-1:0]  trap_code;
  logic                  mret;
  logic                  sret;

  modport decoder (
    output csr_valid, op, addr,
    output trap, trap_code,
    output mret, sret
  );

  modport file (
    input csr_valid, op, addr,
    input trap, trap_code,
    input mret, sret
  );
endinterface

// ==== verilog/csr_decode.sv ====
`timescale 1ns/1ns

`include "csr_params.svh"

module csr_decode (
  input  logic                  i_req,
  input  logic [`CSR_XLEN-1:0]  i_inst,
  input  logic [`CSR_XLEN-1:0]  i_exception_code,
  input  csr_pkg::priv_mode_t   i_mode,
  csr_sys_if.decoder            sys
);

  logic                  is_system;
  logic                  is_priv;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [4:0]            rs2;
  logic                  trap;
  logic [`CSR_XLEN-1:0]  code;

  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign rs2    = i_inst[24:20];

  assign is_system = i_inst[1:0] == 2'b11 && i_inst[6:2] == csr_pkg::OPCODE_SYSTEM;
  // ecall, ebreak, mret and sret have rd = rs1 = 0
  assign is_priv = is_system && funct3 == 3'd0 && i_inst[19:15] == 5'd0 &&
                   i_inst[11:7] == 5'd0;

  // earlier pipeline exception wins over the instruction itself
  always_comb begin
    code = i_exception_code;
    if (code == '0 && is_priv && funct7 == 7'h00) begin
      if (rs2 == 5'd0) begin
        code = csr_pkg::TRAP_ECALL_U + 32'(i_mode);
      end else if (rs2 == 5'd1) begin
        code = csr_pkg::TRAP_BREAKPOINT;
      end
    end
  end

  assign trap = i_req && code != '0;

  assign sys.trap      = trap;
  assign sys.trap_code = code;
  assign sys.op        = csr_pkg::csr_op_t'(funct3);
  assign sys.addr      = i_inst[31:20];
  assign sys.csr_valid = i_req && !trap && is_system && funct3[1:0] != 2'b00; // 100 is reserved
  assign sys.mret = i_req && !trap && is_priv && funct7 == 7'h18 && rs2 == 5'd2;
  assign sys.sret = i_req && !trap && is_priv && funct7 == 7'h08 && rs2 == 5'd2;

endmodule

// ==== verilog/csr_counters.sv ====
`timescale 1ns/1ns

`include "csr_params.svh"

module csr_counters (
  input  logic         clk,
  input  logic         nrst,
  input  logic         i_retire,
  output logic [63:0]  o_cycle,
  output logic [63:0]  o_instret,
  output logic [63:0]  o_time
);

  localparam int DIV_W = $clog2(`CSR_RTC_DIV + 1);

  logic [DIV_W-1:0]  prescale;
  logic              tick;
  logic [63:0]       cycle_q;
  logic [63:0]       instret_q;
  logic [63:0]       time_q;

  assign tick = prescale == DIV_W'(`CSR_RTC_DIV - 1);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      prescale  <= '0;
      cycle_q   <= '0;
      instret_q <= '0;
      time_q    <= '0;
    end else begin
      prescale <= tick ? '0 : prescale + 1'b1;
      cycle_q  <= cycle_q + 64'd1;
      if (i_retire) instret_q <= instret_q + 64'd1;
      if (tick) time_q <= time_q + 64'd1; // one step per CSR_RTC_DIV clocks
    end
  end

  assign o_cycle   = cycle_q;
  assign o_instret = instret_q;
  assign o_time    = time_q;

endmodule

// ==== verilog/csr_file.sv ====
`timescale 1ns/1ns

`include "csr_params.svh"

module csr_file #(
  parameter logic [`CSR_XLEN-1:0] HART_ID = '0
) (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic [`CSR_XLEN-1:0]  i_pc,
  input  logic [`CSR_XLEN-1:0]  i_data,
  input  logic [63:0]           i_cycle,
  input  logic [63:0]           i_instret,
  input  logic [63:0]           i_time,
  csr_sys_if.file               sys,
  output logic [`CSR_XLEN-1:0]  o_data,
  output logic                  o_pc_valid,
  output logic [`CSR_XLEN-1:0]  o_pc,
  output logic [`CSR_XLEN-1:0]  o_trap_code,
  output csr_pkg::priv_mode_t   o_mode
);

  // mxl = 1, extensions I and M
  localparam logic [`CSR_XLEN-1:0] MISA_VAL = {2'b01, 4'b0000, 26'h0001100};

  csr_pkg::priv_mode_t   mode;
  csr_pkg::priv_mode_t   mpp;
  logic                  spp, mpie, spie, mie, sie, sum;
  logic [`CSR_XLEN-1:0]  mtvec, stvec, mscratch, mepc, mcause;
  logic [`CSR_XLEN-1:0]  sepc, scause, mstatush;
  logic [`CSR_XLEN-1:0]  mstatus;
  logic [`CSR_XLEN-1:0]  wdata;
  logic                  status_wr;
  logic [1:0]            wr_mpp;

  always_comb begin
    mstatus = '0;
    mstatus[csr_pkg::MSTATUS_SIE]       = sie;
    mstatus[csr_pkg::MSTATUS_MIE]       = mie;
    mstatus[csr_pkg::MSTATUS_SPIE]      = spie;
    mstatus[csr_pkg::MSTATUS_MPIE]      = mpie;
    mstatus[csr_pkg::MSTATUS_SPP]       = spp;
    mstatus[csr_pkg::MSTATUS_MPP +: 2]  = mpp;
    mstatus[csr_pkg::MSTATUS_SUM]       = sum;
  end

  // old value, also the base for set/clear
  always_comb begin
    case (sys.addr)
      csr_pkg::CSR_MSTATUS:  o_data = mstatus;
      csr_pkg::CSR_MSTATUSH: o_data = mstatush;
      csr_pkg::CSR_MISA:     o_data = MISA_VAL;
      csr_pkg::CSR_MTVEC:    o_data = mtvec;
      csr_pkg::CSR_MSCRATCH: o_data = mscratch;
      csr_pkg::CSR_MEPC:     o_data = mepc;
      csr_pkg::CSR_MCAUSE:   o_data = mcause;
      csr_pkg::CSR_MHARTID:  o_data = HART_ID;
      csr_pkg::CSR_STVEC:    o_data = stvec;
      csr_pkg::CSR_SEPC:     o_data = sepc;
      csr_pkg::CSR_SCAUSE:   o_data = scause;
      csr_pkg::CSR_CYCLE:    o_data = i_cycle[31:0];
      csr_pkg::CSR_TIME:     o_data = i_time[31:0];
      csr_pkg::CSR_INSTRET:  o_data = i_instret[31:0];
      csr_pkg::CSR_CYCLEH:   o_data = i_cycle[63:32];
      csr_pkg::CSR_TIMEH:    o_data = i_time[63:32];
      csr_pkg::CSR_INSTRETH: o_data = i_instret[63:32];
      default:               o_data = '0;
    endcase
  end

  always_comb begin
    case (sys.op)
      csr_pkg::CSRRS, csr_pkg::CSRRSI: wdata = o_data | i_data;
      csr_pkg::CSRRC, csr_pkg::CSRRCI: wdata = o_data & ~i_data;
      default:                         wdata = i_data;
    endcase
  end

  assign status_wr = sys.csr_valid && sys.addr == csr_pkg::CSR_MSTATUS;
  assign wr_mpp    = wdata[csr_pkg::MSTATUS_MPP +: 2];

  always_ff @(posedge clk) begin
    if (!nrst) begin
      mode <= csr_pkg::PRIV_M;
      mpp  <= csr_pkg::PRIV_M;
      spp  <= 1'b0;
      mpie <= 1'b0;
      spie <= 1'b0;
      mie  <= 1'b0;
      sie  <= 1'b0;
      sum  <= 1'b0;
    end else if (sys.trap) begin // every trap lands in M
      mode <= csr_pkg::PRIV_M;
      mpp  <= mode;
      mpie <= mie;
      mie  <= 1'b0;
    end else if (sys.mret) begin
      mode <= mpp;
      mie  <= mpie;
      mpie <= 1'b1;
      mpp  <= csr_pkg::PRIV_U;
    end else if (sys.sret) begin
      mode <= spp ? csr_pkg::PRIV_S : csr_pkg::PRIV_U;
      sie  <= spie;
      spie <= 1'b1;
      spp  <= 1'b0;
    end else if (status_wr) begin
      sie  <= wdata[csr_pkg::MSTATUS_SIE];
      mie  <= wdata[csr_pkg::MSTATUS_MIE];
      spie <= wdata[csr_pkg::MSTATUS_SPIE];
      mpie <= wdata[csr_pkg::MSTATUS_MPIE];
      spp  <= wdata[csr_pkg::MSTATUS_SPP];
      sum  <= wdata[csr_pkg::MSTATUS_SUM];
      if (wr_mpp != 2'b10) mpp <= csr_pkg::priv_mode_t'(wr_mpp); // 2 is reserved, keep old
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      mtvec    <= '0;
      stvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      sepc     <= '0;
      scause   <= '0;
      mstatush <= '0;
    end else begin
      if (sys.trap) begin
        mepc   <= i_pc;
        mcause <= sys.trap_code;
      end
      if (sys.csr_valid) begin
        case (sys.addr)
          csr_pkg::CSR_MTVEC:    mtvec <= wdata;
          csr_pkg::CSR_STVEC:    stvec <= wdata;
          csr_pkg::CSR_MSCRATCH: mscratch <= wdata;
          csr_pkg::CSR_MEPC:     mepc <= wdata;
          csr_pkg::CSR_MCAUSE:   mcause <= wdata;
          csr_pkg::CSR_SEPC:     sepc <= wdata;
          csr_pkg::CSR_SCAUSE:   scause <= wdata;
          csr_pkg::CSR_MSTATUSH: mstatush <= wdata;
          default: ; // read-only or unknown
        endcase
      end
    end
  end

  always_comb begin
    o_pc_valid = 1'b1;
    if (sys.trap) begin
      o_pc = mtvec;
    end else if (sys.mret) begin
      o_pc = mepc;
    end else if (sys.sret) begin
      o_pc = sepc;
    end else begin
      o_pc_valid = 1'b0;
      o_pc       = '0;
    end
  end

  assign o_trap_code = sys.trap_code;
  assign o_mode      = mode;

endmodule

// ==== verilog/csr_unit.sv ====
`timescale 1ns/1ns

`include "csr_params.svh"

module csr_unit #(
  parameter logic [`CSR_XLEN-1:0] HART_ID = `CSR_HART_ID
) (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  i_req,
  input  logic [`CSR_XLEN-1:0]  i_inst,
  input  logic [`CSR_XLEN-1:0]  i_pc,
  input  logic [`CSR_XLEN-1:0]  i_exception_code,
  input  logic [`CSR_XLEN-1:0]  i_data,
  input  logic                  i_retire,
  output logic [`CSR_XLEN-1:0]  o_data,
  output logic                  o_pc_valid,
  output logic [`CSR_XLEN-1:0]  o_pc,
  output logic [`CSR_XLEN-1:0]  o_trap_code,
  output csr_pkg::priv_mode_t   o_mode
);

  csr_sys_if sys_if ();

  logic [63:0] cycle;
  logic [63:0] instret;
  logic [63:0] rtc;

  csr_decode decode_i (
    .i_req            (i_req),
    .i_inst           (i_inst),
    .i_exception_code (i_exception_code),
    .i_mode           (o_mode), // ecall code depends on current mode
    .sys              (sys_if.decoder)
  );

  csr_counters counters_i (
    .clk       (clk),
    .nrst      (nrst),
    .i_retire  (i_retire),
    .o_cycle   (cycle),
    .o_instret (instret),
    .o_time    (rtc)
  );

  csr_file #(
    .HART_ID (HART_ID)
  ) file_i (
    .clk         (clk),
    .nrst        (nrst),
    .i_pc        (i_pc),
    .i_data      (i_data),
    .i_cycle     (cycle),
    .i_instret   (instret),
    .i_time      (rtc),
    .sys         (sys_if.file),
    .o_data      (o_data),
    .o_pc_valid  (o_pc_valid),
    .o_pc        (o_pc),
    .o_trap_code (o_trap_code),
    .o_mode      (o_mode)
  );

endmodule

// ==== verification/csr_unit_tb.sv ====
`timescale 1ns/1ns

`include "csr_params.svh"

module csr_unit_tb;

  logic                 clk = 1'b0;
  logic                 nrst;
  logic                 i_req;
  logic [31:0]          i_inst;
  logic [31:0]          i_pc;
  logic [31:0]          i_exception_code;
  logic [31:0]          i_data;
  logic                 i_retire;
  logic [31:0]          o_data;
  logic                 o_pc_valid;
  logic [31:0]          o_pc;
  logic [31:0]          o_trap_code;
  csr_pkg::priv_mode_t  o_mode;

  // reference model state
  logic [1:0]   m_mode;
  logic [1:0]   m_mpp;
  logic         m_mie;
  logic         m_mpie;
  logic         m_sie;
  logic         m_spie;
  logic         m_spp;
  logic         m_sum;
  logic [31:0]  m_mtvec;
  logic [31:0]  m_stvec;
  logic [31:0]  m_mscratch;
  logic [31:0]  m_mepc;
  logic [31:0]  m_mcause;
  logic [31:0]  m_sepc;
  logic [31:0]  m_scause;
  logic [31:0]  m_mstatush;

  // expected response of the request in flight
  logic [31:0]  exp_data;
  logic         exp_chk;
  logic         exp_pc_valid;
  logic [31:0]  exp_pc;
  logic [31:0]  exp_code;
  logic [1:0]   exp_mode;
  string        test_name;
  logic [31:0]  rng;

  csr_unit dut_i (
    .clk              (clk),
    .nrst             (nrst),
    .i_req            (i_req),
    .i_inst           (i_inst),
    .i_pc             (i_pc),
    .i_exception_code (i_exception_code),
    .i_data           (i_data),
    .i_retire         (i_retire),
    .o_data           (o_data),
    .o_pc_valid       (o_pc_valid),
    .o_pc             (o_pc),
    .o_trap_code      (o_trap_code),
    .o_mode           (o_mode)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng = x;
    return x;
  endfunction

  function automatic logic [31:0] csr_inst(input logic [2:0] op, input logic [11:0] a,
                                           input logic [4:0] rs1);
    return {a, rs1, op, 5'd1, 7'h73}; // rd = x1
  endfunction

  function automatic logic [31:0] model_mstatus();
    logic [31:0] v;
    v = '0;
    v[1]     = m_sie;
    v[3]     = m_mie;
    v[5]     = m_spie;
    v[7]     = m_mpie;
    v[8]     = m_spp;
    v[12:11] = m_mpp;
    v[18]    = m_sum;
    return v;
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] a);
    logic [31:0] v;
    case (a)
      12'h300: v = model_mstatus();
      12'h301: v = 32'h4000_1100;
      12'h305: v = m_mtvec;
      12'h310: v = m_mstatush;
      12'h340: v = m_mscratch;
      12'h341: v = m_mepc;
      12'h342: v = m_mcause;
      12'h105: v = m_stvec;
      12'h141: v = m_sepc;
      12'h142: v = m_scause;
      default: v = 32'h0; // mhartid and the counter highs read 0 here
    endcase
    return v;
  endfunction

  // expected o_data, redirect and next state for one request
  function automatic logic [31:0] model_step(input logic [31:0] inst, input logic [31:0] pc,
                                             input logic [31:0] exc, input logic [31:0] data);
    logic [2:0]   f3;
    logic [11:0]  a;
    logic [31:0]  old;
    logic [31:0]  nv;
    logic [31:0]  code;
    f3   = inst[14:12];
    a    = inst[31:20];
    old  = model_read(a);
    code = exc;
    if (code == 32'd0 && inst == 32'h0000_0073) code = 32'd8 + {30'd0, m_mode};
    else if (code == 32'd0 && inst == 32'h0010_0073) code = 32'd3;
    exp_code     = code;
    exp_pc_valid = 1'b1;
    exp_pc       = 32'd0;
    if (code != 32'd0) begin
      exp_pc   = m_mtvec;
      m_mepc   = pc;
      m_mcause = code;
      m_mpp    = m_mode;
      m_mpie   = m_mie;
      m_mie    = 1'b0;
      m_mode   = 2'd3;
    end else if (inst == 32'h3020_0073) begin // mret
      exp_pc = m_mepc;
      m_mode = m_mpp;
      m_mie  = m_mpie;
      m_mpie = 1'b1;
      m_mpp  = 2'd0;
    end else if (inst == 32'h1020_0073) begin // sret
      exp_pc = m_sepc;
      m_mode = m_spp ? 2'd1 : 2'd0;
      m_sie  = m_spie;
      m_spie = 1'b1;
      m_spp  = 1'b0;
    end else begin
      exp_pc_valid = 1'b0;
      if (inst[6:0] == 7'h73 && f3 != 3'd0 && f3 != 3'd4) begin
        case (f3[1:0])
          2'b01:   nv = data;
          2'b10:   nv = old | data;
          default: nv = old & ~data;
        endcase
        case (a)
          12'h300: begin
            m_sie  = nv[1];
            m_mie  = nv[3];
            m_spie = nv[5];
            m_mpie = nv[7];
            m_spp  = nv[8];
            m_sum  = nv[18];
            if (nv[12:11] != 2'b10) m_mpp = nv[12:11];
          end
          12'h305: m_mtvec    = nv;
          12'h310: m_mstatush = nv;
          12'h340: m_mscratch = nv;
          12'h341: m_mepc     = nv;
          12'h342: m_mcause   = nv;
          12'h105: m_stvec    = nv;
          12'h141: m_sepc     = nv;
          12'h142: m_scause   = nv;
          default: ;
        endcase
      end
    end
    return old;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s %s expected %h actual %h", test_name, name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic issue(input logic [31:0] inst, input logic [31:0] pc, input logic [31:0] exc,
                       input logic [31:0] data, input logic chk);
    @(posedge clk);
    exp_mode = m_mode; // dut mode changes one edge later
    exp_chk  = chk;
    exp_data = model_step(inst, pc, exc, data);
    i_req            <= 1'b1;
    i_inst           <= inst;
    i_pc             <= pc;
    i_exception_code <= exc;
    i_data           <= data;
  endtask

  task automatic idle(input logic retire);
    @(posedge clk);
    exp_mode = m_mode;
    i_req    <= 1'b0;
    i_retire <= retire;
  endtask

  task automatic read_csr(input logic [11:0] a, input logic chk, output logic [31:0] v);
    issue(csr_inst(3'b010, a, 5'd0), 32'd0, 32'd0, 32'd0, chk);
    @(negedge clk);
    v = o_data;
  endtask

  task automatic wait_time_tick();
    logic [31:0] t0;
    logic [31:0] t;
    int          n;
    read_csr(12'hc01, 1'b0, t0);
    t = t0;
    n = 0;
    while (t == t0) begin
      if (n == 4 * `CSR_RTC_DIV) begin
        $display("timed out waiting for the time counter to advance");
        $display("TEST FAILED");
        $fatal(1, "timeout");
      end
      read_csr(12'hc01, 1'b0, t);
      n++;
    end
  endtask

  // combinational outputs are settled by the falling edge
  always @(negedge clk) begin
    if (nrst) begin
      check_value("mode", {30'd0, exp_mode}, 32'(o_mode));
      if (i_req) begin
        if (exp_chk) check_value("data", exp_data, o_data);
        check_value("pc_valid", {31'd0, exp_pc_valid}, {31'd0, o_pc_valid});
        if (exp_pc_valid) begin
          check_value("pc", exp_pc, o_pc);
          check_value("trap_code", exp_code, o_trap_code);
        end
      end else begin
        check_value("pc_valid idle", 32'd0, {31'd0, o_pc_valid});
      end
    end
  end

  initial begin
    logic [31:0] v;
    logic [31:0] d;
    logic [31:0] pc;
    logic [31:0] operand;
    logic [31:0] c0;
    logic [31:0] r0;
    logic [31:0] t0;
    logic [31:0] c1;
    logic [31:0] r1;
    logic [31:0] t1;
    logic [31:0] dt;
    logic [2:0]  op;
    logic [4:0]  rs1;
    logic [11:0] a;
    int          k;
    int          n_loop;
    int          i;
    rng              = 32'h2174;
    nrst             = 1'b0;
    i_req            = 1'b0;
    i_inst           = 32'd0;
    i_pc             = 32'd0;
    i_exception_code = 32'd0;
    i_data           = 32'd0;
    i_retire         = 1'b0;
    m_mode     = 2'd3;
    m_mpp      = 2'd3;
    m_mie      = 1'b0;
    m_mpie     = 1'b0;
    m_sie      = 1'b0;
    m_spie     = 1'b0;
    m_spp      = 1'b0;
    m_sum      = 1'b0;
    m_mtvec    = 32'd0;
    m_stvec    = 32'd0;
    m_mscratch = 32'd0;
    m_mepc     = 32'd0;
    m_mcause   = 32'd0;
    m_sepc     = 32'd0;
    m_scause   = 32'd0;
    m_mstatush = 32'd0;
    exp_data     = 32'd0;
    exp_chk      = 1'b0;
    exp_pc_valid = 1'b0;
    exp_pc       = 32'd0;
    exp_code     = 32'd0;
    exp_mode     = 2'd3;
    test_name    = "reset";
    repeat (2) @(posedge clk);
    nrst             <= 1'b1;
    i_inst           <= 32'h0000_0073; // pending ecall and exception with i_req low
    i_exception_code <= 32'd2;

    idle(1'b0);
    idle(1'b0);
    read_csr(12'h300, 1'b1, v);
    check_value("mstatus", 32'h0000_1800, v);
    read_csr(12'h301, 1'b1, v);
    check_value("misa", 32'h4000_1100, v);
    read_csr(12'hf14, 1'b1, v);
    check_value("mhartid", 32'd0, v);
    check_value("mode", 32'd3, 32'(o_mode));

    test_name = "rmw";
    for (i = 0; i < 32; i++) begin
      d = xorshift32();
      case (d[1:0])
        2'd0:    a = 12'h305;
        2'd1:    a = 12'h340;
        2'd2:    a = 12'h341;
        default: a = 12'h105;
      endcase
      case (d[4:2])
        3'd0, 3'd6: op = 3'b001;
        3'd1, 3'd7: op = 3'b010;
        3'd2:       op = 3'b011;
        3'd3:       op = 3'b101;
        3'd4:       op = 3'b110;
        default:    op = 3'b111;
      endcase
      if (op[2]) begin // zimm comes in as the operand
        rs1     = d[31:27];
        operand = {27'd0, d[31:27]};
      end else begin
        rs1     = 5'd6;
        operand = xorshift32();
      end
      issue(csr_inst(op, a, rs1), 32'd0, 32'd0, operand, 1'b1);
    end
    read_csr(12'h305, 1'b1, v);
    read_csr(12'h340, 1'b1, v);
    read_csr(12'h341, 1'b1, v);
    read_csr(12'h105, 1'b1, v);
    read_csr(12'h342, 1'b1, v); // mepc writes leave mcause alone

    test_name = "ecall";
    issue(csr_inst(3'b110, 12'h300, 5'd8), 32'd0, 32'd0, 32'd8, 1'b1); // set mie
    pc = xorshift32() & ~32'h3;
    issue(32'h0000_0073, pc, 32'd0, 32'd0, 1'b1);
    @(negedge clk);
    check_value("redirect", 32'd1, {31'd0, o_pc_valid});
    check_value("code", 32'd11, o_trap_code);
    read_csr(12'h341, 1'b1, v);
    check_value("mepc", pc, v);
    read_csr(12'h342, 1'b1, v);
    check_value("mcause", 32'd11, v);
    read_csr(12'h300, 1'b1, v);
    check_value("mie", 32'd0, {31'd0, v[3]});
    check_value("mpie", 32'd1, {31'd0, v[7]});

    test_name = "ebreak";
    issue(32'h0010_0073, xorshift32() & ~32'h3, 32'd0, 32'd0, 1'b1);
    @(negedge clk);
    check_value("code", 32'd3, o_trap_code);

    test_name = "exception";
    issue(csr_inst(3'b001, 12'h340, 5'd3), 32'h0000_0100, 32'd5, xorshift32(), 1'b1);
    @(negedge clk);
    check_value("code", 32'd5, o_trap_code);
    read_csr(12'h342, 1'b1, v);
    check_value("mcause", 32'd5, v);
    read_csr(12'h340, 1'b1, v); // mscratch left alone

    test_name = "mret";
    issue(csr_inst(3'b011, 12'h300, 5'd4), 32'd0, 32'd0, 32'h0000_1800, 1'b1); // mpp to U
    pc = xorshift32() & ~32'h3;
    issue(csr_inst(3'b001, 12'h341, 5'd5), 32'd0, 32'd0, pc, 1'b1);
    issue(32'h3020_0073, 32'd0, 32'd0, 32'd0, 1'b1);
    @(negedge clk);
    check_value("target", pc, o_pc);
    idle(1'b0);
    @(negedge clk);
    check_value("mode", 32'd0, 32'(o_mode));

    test_name = "ecall_u";
    issue(32'h0000_0073, pc + 32'd4, 32'd0, 32'd0, 1'b1);
    @(negedge clk);
    check_value("code", 32'd8, o_trap_code);

    test_name = "sret";
    pc = xorshift32() & ~32'h3;
    issue(csr_inst(3'b001, 12'h141, 5'd7), 32'd0, 32'd0, pc, 1'b1);
    issue(32'h1020_0073, 32'd0, 32'd0, 32'd0, 1'b1);
    @(negedge clk);
    check_value("target", pc, o_pc);

    test_name = "counters";
    idle(1'b0);
    wait_time_tick();
    read_csr(12'hc00, 1'b0, c0);
    read_csr(12'hc02, 1'b0, r0);
    read_csr(12'hc01, 1'b0, t0);
    k      = 0;
    n_loop = 20 + int'(xorshift32() & 32'h7);
    for (i = 0; i < n_loop; i++) begin
      d = xorshift32();
      idle(d[0]);
      if (d[0]) k++;
    end
    idle(1'b0);
    read_csr(12'hc00, 1'b0, c1);
    read_csr(12'hc02, 1'b0, r1);
    read_csr(12'hc01, 1'b0, t1);
    // each pair of reads is n_loop + 4 cycles apart
    check_value("cycle delta", 32'(n_loop + 4), c1 - c0);
    check_value("instret delta", 32'(k), r1 - r0);
    dt = t1 - t0;
    if (dt < 32'((n_loop + 4) / `CSR_RTC_DIV) || dt > 32'((n_loop + 4) / `CSR_RTC_DIV + 1)) begin
      $display("[ERROR] %s time delta expected %0d to %0d actual %0d", test_name,
               (n_loop + 4) / `CSR_RTC_DIV, (n_loop + 4) / `CSR_RTC_DIV + 1, dt);
      $display("TEST FAILED");
      $fatal(1, "time delta out of range");
    end
    read_csr(12'hc80, 1'b1, v);
    read_csr(12'hc81, 1'b1, v);
    read_csr(12'hc82, 1'b1, v);
    idle(1'b0);

    $display("TEST OK");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+include
verilog/csr_pkg.sv
verilog/csr_sys_if.sv
verilog/csr_decode.sv
verilog/csr_counters.sv
verilog/csr_file.sv
verilog/csr_unit.sv
verification/csr_unit_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
TOP        := csr_unit_tb
RTL_TOP    := csr_unit
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
